/* Bender.yml */
package:
  name: async_fifo

sources:
  - src/fifo_pkg.sv
  - src/gray_pkg.sv
  - src/shift_reg.sv
  - src/ram_sdp.sv
  - src/wr_ptr_full.sv
  - src/rd_ptr_empty.sv
  - src/async_fifo.sv
  - target: test
    files:
      - verif/fifo_checker.sv
      - verif/tb_async_fifo.sv

/* async_fifo.f */
src/fifo_pkg.sv
src/gray_pkg.sv
src/shift_reg.sv
src/ram_sdp.sv
src/wr_ptr_full.sv
src/rd_ptr_empty.sv
src/async_fifo.sv
verif/fifo_checker.sv
verif/tb_async_fifo.sv

/* src/async_fifo.sv */
`timescale 1ns/1ps

module async_fifo #(
    parameter int FIFO_WIDTH    = fifo_pkg::FIFO_WIDTH_DEF,
    parameter int FIFO_DEPTH    = fifo_pkg::FIFO_DEPTH_DEF,
    parameter int CDC_REG_NUM   = fifo_pkg::CDC_REG_NUM_DEF,
    parameter int ALMOST_MARGIN = fifo_pkg::ALMOST_MARGIN_DEF
) (
    input  logic                  wr_clk_i,
    input  logic                  rd_clk_i,
    input  logic                  arst_n_i,

    input  logic [FIFO_WIDTH-1:0] wr_data_i,
    input  logic                  push_i,
    input  logic                  pop_i,
    output logic [FIFO_WIDTH-1:0] rd_data_o,

    output logic                  full_o,
    output logic                  a_full_o,
    output logic                  empty_o,
    output logic                  a_empty_o
);

    if (CDC_REG_NUM < 2) begin : g_cdc_reg_num_err
        $error("CDC_REG_NUM must be at least 2.");
    end

    localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

    // write domain.
    logic                  wr_en;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [  ADDR_WIDTH:0] wr_ptr_gray;
    logic [  ADDR_WIDTH:0] wq2_rptr;

    // read domain.
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic [  ADDR_WIDTH:0] rd_ptr_gray;
    logic [  ADDR_WIDTH:0] rq2_wptr;

    // ==========================================================================
    // pointer blocks
    // ==========================================================================

    wr_ptr_full #(
        .ADDR_WIDTH   (ADDR_WIDTH),
        .ALMOST_MARGIN(ALMOST_MARGIN)
    ) u_wr_ptr_full (
        .wr_clk_i     (wr_clk_i),
        .arst_n_i     (arst_n_i),
        .push_i       (push_i),
        .wq2_rptr_i   (wq2_rptr),
        .wr_en_o      (wr_en),
        .wr_addr_o    (wr_addr),
        .wr_ptr_gray_o(wr_ptr_gray),
        .full_o       (full_o),
        .a_full_o     (a_full_o)
    );

    rd_ptr_empty #(
        .ADDR_WIDTH   (ADDR_WIDTH),
        .ALMOST_MARGIN(ALMOST_MARGIN)
    ) u_rd_ptr_empty (
        .rd_clk_i     (rd_clk_i),
        .arst_n_i     (arst_n_i),
        .pop_i        (pop_i),
        .rq2_wptr_i   (rq2_wptr),
        .rd_addr_o    (rd_addr),
        .rd_ptr_gray_o(rd_ptr_gray),
        .empty_o      (empty_o),
        .a_empty_o    (a_empty_o)
    );

    // ==========================================================================
    // pointer crossings
    // ==========================================================================

    // read pointer into the write domain.
    shift_reg #(
        .DATA_WIDTH(ADDR_WIDTH + 1),
        .DELAY     (CDC_REG_NUM)
    ) wr_shift_reg (
        .clk_i   (wr_clk_i),
        .arst_n_i(arst_n_i),
        .data_i  (rd_ptr_gray),
        .data_o  (wq2_rptr)
    );

    // write pointer into the read domain.
    shift_reg #(
        .DATA_WIDTH(ADDR_WIDTH + 1),
        .DELAY     (CDC_REG_NUM)
    ) rd_shift_reg (
        .clk_i   (rd_clk_i),
        .arst_n_i(arst_n_i),
        .data_i  (wr_ptr_gray),
        .data_o  (rq2_wptr)
    );

    // ==========================================================================
    // storage
    // ==========================================================================

    ram_sdp #(
        .MEM_DEPTH (FIFO_DEPTH),
        .DATA_WIDTH(FIFO_WIDTH)
    ) u_ram_sdp (
        .a_clk_i  (wr_clk_i),
        .a_wr_en_i(wr_en),
        .a_addr_i (wr_addr),
        .a_data_i (wr_data_i),
        .b_addr_i (rd_addr),
        .b_data_o (rd_data_o)
    );

endmodule

/* src/fifo_pkg.sv */
package fifo_pkg;

    // ==========================================================================
    // default sizing of the dual-clock FIFO
    // ==========================================================================

    // width of one data word in bits.
    localparam int FIFO_WIDTH_DEF = 32;

    // number of entries.
    // This must be a power of two so the pointer wrap bit works.
    localparam int FIFO_DEPTH_DEF = 16;

    // synchronizer stages per pointer crossing, at least two.
    localparam int CDC_REG_NUM_DEF = 2;

    // ==========================================================================
    // almost flags
    // ==========================================================================

    // a_full_o is raised with FIFO_DEPTH - ALMOST_MARGIN or more words stored.
    // a_empty_o is raised with ALMOST_MARGIN or fewer words stored.
    localparam int ALMOST_MARGIN_DEF = 4;

endpackage

/* src/gray_pkg.sv */
package gray_pkg;

    // widest pointer the helpers handle, wrap bit included.
    localparam int PTR_MAX_WIDTH = 32;

    // pointers are zero extended to this type before calling a helper.
    typedef logic [PTR_MAX_WIDTH-1:0] ptr_t;

    // ==========================================================================
    // code conversion
    // ==========================================================================

    function automatic ptr_t bin2gray(ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    // leading zeros of a narrow pointer stay zero, so the result is exact.
    function automatic ptr_t gray2bin(ptr_t gray);
        ptr_t bin;
        bin[PTR_MAX_WIDTH-1] = gray[PTR_MAX_WIDTH-1];
        for (int i = PTR_MAX_WIDTH - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    // full when the write pointer has lapped the read pointer by one turn.
    function automatic logic gray_full(ptr_t wr_gray, ptr_t rd_gray_sync, int unsigned width);
        ptr_t mask;
        mask = '0;
        mask[width-1] = 1'b1;
        mask[width-2] = 1'b1;
        return wr_gray == (rd_gray_sync ^ mask);
    endfunction

endpackage

/* src/ram_sdp.sv */
`timescale 1ns/1ps

module ram_sdp #(
    parameter  int MEM_DEPTH  = 16,
    parameter  int DATA_WIDTH = 32,
    localparam int ADDR_WIDTH = $clog2(MEM_DEPTH)
) (
    // write port, in the write clock domain.
    input  logic                  a_clk_i,
    input  logic                  a_wr_en_i,
    input  logic [ADDR_WIDTH-1:0] a_addr_i,
    input  logic [DATA_WIDTH-1:0] a_data_i,

    // read port, no clock and no latency.
    input  logic [ADDR_WIDTH-1:0] b_addr_i,
    output logic [DATA_WIDTH-1:0] b_data_o
);

    logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];

    // ==========================================================================
    // write port
    // ==========================================================================

    always_ff @(posedge a_clk_i) begin
        if (a_wr_en_i) begin
            mem[a_addr_i] <= a_data_i;
        end
    end

    // ==========================================================================
    // read port
    // ==========================================================================

    // the read side only addresses an entry once its write pointer update
    // has crossed over, so the word is stable long before it is used.
    assign b_data_o = mem[b_addr_i];

endmodule

/* src/rd_ptr_empty.sv */
`timescale 1ns/1ps

module rd_ptr_empty #(
    parameter int ADDR_WIDTH    = 4,
    parameter int ALMOST_MARGIN = 4
) (
    input  logic                  rd_clk_i,
    input  logic                  arst_n_i,
    input  logic                  pop_i,
    input  logic [  ADDR_WIDTH:0] rq2_wptr_i,
    output logic [ADDR_WIDTH-1:0] rd_addr_o,
    output logic [  ADDR_WIDTH:0] rd_ptr_gray_o,
    output logic                  empty_o,
    output logic                  a_empty_o
);

    localparam int PTR_W = ADDR_WIDTH + 1;
    localparam logic [ADDR_WIDTH:0] AEMPTY_LEVEL = PTR_W'(ALMOST_MARGIN);

    logic [1:0]          rst_sync;
    logic                rd_rst_n;
    logic                rd_en;
    logic [ADDR_WIDTH:0] rd_bin;
    logic [ADDR_WIDTH:0] rd_bin_next;
    logic [ADDR_WIDTH:0] rd_gray_next;
    logic [ADDR_WIDTH:0] wr_bin_sync;
    logic [ADDR_WIDTH:0] rd_level_next;

    // ==========================================================================
    // reset release into rd_clk_i
    // ==========================================================================

    always_ff @(posedge rd_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rst_sync <= 2'b00;
        end else begin
            rst_sync <= {rst_sync[0], 1'b1};
        end
    end

    assign rd_rst_n = rst_sync[1];

    // ==========================================================================
    // pointer and flags
    // ==========================================================================

    // a pop is taken only while a word is stored.
    assign rd_en       = pop_i & ~empty_o;
    assign rd_bin_next = rd_bin + PTR_W'(rd_en);

    assign rd_gray_next = PTR_W'(gray_pkg::bin2gray(gray_pkg::ptr_t'(rd_bin_next)));
    assign wr_bin_sync  = PTR_W'(gray_pkg::gray2bin(gray_pkg::ptr_t'(rq2_wptr_i)));

    // the write pointer seen here is old, so the level is never too high.
    assign rd_level_next = wr_bin_sync - rd_bin_next;

    always_ff @(posedge rd_clk_i or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            rd_bin        <= '0;
            rd_ptr_gray_o <= '0;
            empty_o       <= 1'b1;
            a_empty_o     <= 1'b1;
        end else begin
            rd_bin        <= rd_bin_next;
            rd_ptr_gray_o <= rd_gray_next;
            empty_o       <= (rd_gray_next == rq2_wptr_i);
            a_empty_o     <= (rd_level_next <= AEMPTY_LEVEL);
        end
    end

    // head of the FIFO, read by the RAM without a clock edge.
    assign rd_addr_o = rd_bin[ADDR_WIDTH-1:0];

endmodule

/* src/shift_reg.sv */
`timescale 1ns/1ps

module shift_reg #(
    parameter int DATA_WIDTH = 5,
    parameter int DELAY      = 2
) (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic [DATA_WIDTH-1:0] data_i,
    output logic [DATA_WIDTH-1:0] data_o
);

    // stage 0 is the one that may go metastable.
    logic [DATA_WIDTH-1:0] stage [DELAY];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < DELAY; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= data_i;
            for (int i = 1; i < DELAY; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    // only one bit of a Gray pointer changes per step, so the last stage
    // always shows either the old or the new pointer value.
    assign data_o = stage[DELAY-1];

endmodule

/* src/wr_ptr_full.sv */
`timescale 1ns/1ps

module wr_ptr_full #(
    parameter int ADDR_WIDTH    = 4,
    parameter int ALMOST_MARGIN = 4
) (
    input  logic                  wr_clk_i,
    input  logic                  arst_n_i,
    input  logic                  push_i,
    input  logic [  ADDR_WIDTH:0] wq2_rptr_i,
    output logic                  wr_en_o,
    output logic [ADDR_WIDTH-1:0] wr_addr_o,
    output logic [  ADDR_WIDTH:0] wr_ptr_gray_o,
    output logic                  full_o,
    output logic                  a_full_o
);

    localparam int PTR_W = ADDR_WIDTH + 1;
    localparam int DEPTH = 1 << ADDR_WIDTH;
    localparam logic [ADDR_WIDTH:0] AFULL_LEVEL = PTR_W'(DEPTH - ALMOST_MARGIN);

    logic [1:0]          rst_sync;
    logic                wr_rst_n;
    logic [ADDR_WIDTH:0] wr_bin;
    logic [ADDR_WIDTH:0] wr_bin_next;
    logic [ADDR_WIDTH:0] wr_gray_next;
    logic [ADDR_WIDTH:0] rd_bin_sync;
    logic [ADDR_WIDTH:0] wr_level_next;
    logic                full_next;

    // ==========================================================================
    // reset release into wr_clk_i
    // ==========================================================================

    always_ff @(posedge wr_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rst_sync <= 2'b00;
        end else begin
            rst_sync <= {rst_sync[0], 1'b1};
        end
    end

    assign wr_rst_n = rst_sync[1];

    // ==========================================================================
    // pointer and flags
    // ==========================================================================

    // a push is taken only while there is room.
    assign wr_en_o     = push_i & ~full_o;
    assign wr_bin_next = wr_bin + PTR_W'(wr_en_o);

    assign wr_gray_next = PTR_W'(gray_pkg::bin2gray(gray_pkg::ptr_t'(wr_bin_next)));
    assign rd_bin_sync  = PTR_W'(gray_pkg::gray2bin(gray_pkg::ptr_t'(wq2_rptr_i)));

    assign full_next = gray_pkg::gray_full(gray_pkg::ptr_t'(wr_gray_next),
                                           gray_pkg::ptr_t'(wq2_rptr_i), PTR_W);

    // the read pointer seen here is old, so the level is never too low.
    assign wr_level_next = wr_bin_next - rd_bin_sync;

    always_ff @(posedge wr_clk_i or negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            wr_bin        <= '0;
            wr_ptr_gray_o <= '0;
            full_o        <= 1'b0;
            a_full_o      <= 1'b0;
        end else begin
            wr_bin        <= wr_bin_next;
            wr_ptr_gray_o <= wr_gray_next;
            full_o        <= full_next;
            a_full_o      <= (wr_level_next >= AFULL_LEVEL);
        end
    end

    assign wr_addr_o = wr_bin[ADDR_WIDTH-1:0];

endmodule

/* verif/fifo_checker.sv */
`timescale 1ns/1ps

module fifo_checker #(
    parameter int FIFO_WIDTH    = 32,
    parameter int FIFO_DEPTH    = 16,
    parameter int ALMOST_MARGIN = 4
) (
    input  logic                  wr_clk_i,
    input  logic                  rd_clk_i,
    input  logic                  arst_n_i,
    input  logic [FIFO_WIDTH-1:0] wr_data_i,
    input  logic                  push_i,
    input  logic                  pop_i,
    input  logic [FIFO_WIDTH-1:0] rd_data_i,
    input  logic                  full_i,
    input  logic                  a_full_i,
    input  logic                  empty_i,
    input  logic                  a_empty_i
);

    // words accepted by the FIFO and not yet popped, oldest first.
    logic [FIFO_WIDTH-1:0] ref_q [$];

    int test_num      = 0;
    int test_errs     = 0;
    int size_at_start = 0;
    int pass_cnt      = 0;
    int fail_cnt      = 0;

    // ==========================================================================
    // reference model
    // ==========================================================================

    always @(negedge arst_n_i) begin
        ref_q.delete();
    end

    always @(posedge wr_clk_i) begin
        if (arst_n_i && push_i && !full_i) begin
            ref_q.push_back(wr_data_i);
        end
    end

    always @(posedge rd_clk_i) begin
        if (arst_n_i && pop_i && !empty_i) begin
            if (ref_q.size() == 0) begin
                $display("at %0d ns a pop was accepted while no word was outstanding", $time);
                test_errs++;
            end else begin
                if (rd_data_i !== ref_q[0]) begin
                    $display("MISMATCH at %0d ns: rd_data_o got %h, expected %h",
                             $time, rd_data_i, ref_q[0]);
                    test_errs++;
                end
                void'(ref_q.pop_front());
            end
        end
    end

    // ==========================================================================
    // per-test checks
    // ==========================================================================

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("MISMATCH at %0d ns: %s got %b, expected %b", $time, name, got, expected);
            test_errs++;
        end
    endtask

    task automatic check_level(input int got, input int expected);
        if (got != expected) begin
            $display("at %0d ns the FIFO holds %0d words where %0d were expected",
                     $time, got, expected);
            test_errs++;
        end
    endtask

    task automatic start_test();
        test_errs     = 0;
        size_at_start = ref_q.size();
    endtask

    task automatic end_test(input string op_name, input int count);
        int k;
        int expect_k;
        k = ref_q.size();
        test_num++;
        case (op_name)
            "PUSH_BURST": begin
                expect_k = size_at_start + count;
                if (expect_k > FIFO_DEPTH) begin
                    expect_k = FIFO_DEPTH;
                end
                check_level(k, expect_k);
                if (k == FIFO_DEPTH) begin
                    check_flag("full_o", full_i, 1'b1);
                    check_flag("a_full_o", a_full_i, 1'b1);
                end
            end
            "POP_BURST": begin
                expect_k = (size_at_start > count) ? size_at_start - count : 0;
                check_level(k, expect_k);
                if (k == 0) begin
                    check_flag("empty_o", empty_i, 1'b1);
                end
            end
            "SETTLE": begin
                // both pointers have crossed over, so every flag is exact.
                check_flag("full_o", full_i, k == FIFO_DEPTH);
                check_flag("a_full_o", a_full_i, k >= FIFO_DEPTH - ALMOST_MARGIN);
                check_flag("empty_o", empty_i, k == 0);
                check_flag("a_empty_o", a_empty_i, k <= ALMOST_MARGIN);
            end
            "RESET": begin
                check_flag("empty_o", empty_i, 1'b1);
                check_flag("a_empty_o", a_empty_i, 1'b1);
                check_flag("full_o", full_i, 1'b0);
                check_flag("a_full_o", a_full_i, 1'b0);
            end
            default: begin
            end
        endcase
        if (test_errs == 0) begin
            pass_cnt++;
            $display("test %0d %s: pass", test_num, op_name);
        end else begin
            fail_cnt++;
            $display("test %0d %s: fail with %0d errors", test_num, op_name, test_errs);
        end
    endtask

    task automatic report();
        $display("summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
    endtask

endmodule

/* verif/fifo_patterns.txt */
# opcode      start value (hex)   count
# pushed data is the start value plus the word index, the value is unused otherwise
SETTLE        00000000   10
PUSH_BURST    00000100   20
SETTLE        00000000   10
POP_BURST     00000000   20
SETTLE        00000000   10
POP_BURST     00000000   3
SETTLE        00000000   10
PUSH_BURST    00000200   3
SETTLE        00000000   10
PUSH_BURST    00000300   2
SETTLE        00000000   10
PUSH_BURST    00000400   7
SETTLE        00000000   10
MIXED         00001000   40
SETTLE        00000000   10
MIXED         00002000   60
SETTLE        00000000   10
RESET         00000000   5
SETTLE        00000000   10
PUSH_BURST    00005000   6
SETTLE        00000000   10
POP_BURST     00000000   6
SETTLE        00000000   10
MIXED         00006000   30
SETTLE        00000000   10
PUSH_BURST    00007000   9
SETTLE        00000000   10
POP_BURST     00000000   20
SETTLE        00000000   10

/* verif/tb_async_fifo.sv */
`timescale 1ns/1ps

module tb_async_fifo;

    localparam int FIFO_WIDTH    = fifo_pkg::FIFO_WIDTH_DEF;
    localparam int FIFO_DEPTH    = fifo_pkg::FIFO_DEPTH_DEF;
    localparam int CDC_REG_NUM   = fifo_pkg::CDC_REG_NUM_DEF;
    localparam int ALMOST_MARGIN = fifo_pkg::ALMOST_MARGIN_DEF;

    typedef enum {OP_PUSH_BURST, OP_POP_BURST, OP_MIXED, OP_SETTLE, OP_RESET, OP_UNKNOWN} op_e;

    logic                  wr_clk = 1'b0;
    logic                  rd_clk = 1'b0;
    logic                  arst_n;
    logic [FIFO_WIDTH-1:0] wr_data;
    logic                  push;
    logic                  pop;
    logic [FIFO_WIDTH-1:0] rd_data;
    logic                  full;
    logic                  a_full;
    logic                  empty;
    logic                  a_empty;

    op_e                   op_q    [$];
    string                 name_q  [$];
    logic [FIFO_WIDTH-1:0] value_q [$];
    int                    count_q [$];
    int                    bad_lines   = 0;
    int                    cycles      = 0;
    int                    cycle_limit = 0;
    logic [31:0]           rng_state   = 32'd52;

    always #50 wr_clk = ~wr_clk;
    always #65 rd_clk = ~rd_clk;

    async_fifo #(
        .FIFO_WIDTH   (FIFO_WIDTH),
        .FIFO_DEPTH   (FIFO_DEPTH),
        .CDC_REG_NUM  (CDC_REG_NUM),
        .ALMOST_MARGIN(ALMOST_MARGIN)
    ) u_async_fifo (
        .wr_clk_i (wr_clk),
        .rd_clk_i (rd_clk),
        .arst_n_i (arst_n),
        .wr_data_i(wr_data),
        .push_i   (push),
        .pop_i    (pop),
        .rd_data_o(rd_data),
        .full_o   (full),
        .a_full_o (a_full),
        .empty_o  (empty),
        .a_empty_o(a_empty)
    );

    fifo_checker #(
        .FIFO_WIDTH   (FIFO_WIDTH),
        .FIFO_DEPTH   (FIFO_DEPTH),
        .ALMOST_MARGIN(ALMOST_MARGIN)
    ) u_fifo_checker (
        .wr_clk_i (wr_clk),
        .rd_clk_i (rd_clk),
        .arst_n_i (arst_n),
        .wr_data_i(wr_data),
        .push_i   (push),
        .pop_i    (pop),
        .rd_data_i(rd_data),
        .full_i   (full),
        .a_full_i (a_full),
        .empty_i  (empty),
        .a_empty_i(a_empty)
    );

    always @(posedge wr_clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d write clock cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ==========================================================================
    // pattern file
    // ==========================================================================

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic op_e decode_op(input string s);
        case (s)
            "PUSH_BURST": return OP_PUSH_BURST;
            "POP_BURST":  return OP_POP_BURST;
            "MIXED":      return OP_MIXED;
            "SETTLE":     return OP_SETTLE;
            "RESET":      return OP_RESET;
            default:      return OP_UNKNOWN;
        endcase
    endfunction

    task automatic read_patterns(output bit ok);
        int                    fd;
        int                    total;
        int                    count;
        string                 line;
        string                 op_str;
        logic [FIFO_WIDTH-1:0] value;
        ok    = 1'b0;
        total = 0;
        fd    = $fopen("verif/fifo_patterns.txt", "r");
        if (fd == 0) begin
            $display("the pattern file verif/fifo_patterns.txt could not be opened");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 2 && line[0] != "#") begin
                    if ($sscanf(line, "%s %h %d", op_str, value, count) == 3) begin
                        op_q.push_back(decode_op(op_str));
                        name_q.push_back(op_str);
                        value_q.push_back(value);
                        count_q.push_back(count);
                        total += count;
                    end
                end
            end
            $fclose(fd);
            // the slower read clock and the random gaps stay well inside 3x.
            cycle_limit = 3 * total + 20 * op_q.size() + 500;
            ok = (op_q.size() > 0);
        end
    endtask

    // ==========================================================================
    // stimulus
    // ==========================================================================

    task automatic apply_reset(input int count);
        @(negedge wr_clk);
        push   = 1'b0;
        pop    = 1'b0;
        arst_n = 1'b0;
        repeat (count) @(negedge wr_clk);
        arst_n = 1'b1;
        // let both reset synchronizers release.
        repeat (4) @(negedge rd_clk);
    endtask

    task automatic push_burst(input logic [FIFO_WIDTH-1:0] value, input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge wr_clk);
            push    = 1'b1;
            wr_data = value + FIFO_WIDTH'(i);
        end
        @(negedge wr_clk);
        push = 1'b0;
    endtask

    task automatic pop_burst(input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge rd_clk);
            pop = 1'b1;
        end
        @(negedge rd_clk);
        pop = 1'b0;
    endtask

    // full and empty only change at the rising edge, so the value seen at the
    // falling edge decides whether the next edge takes the request.
    task automatic mixed_push(input logic [FIFO_WIDTH-1:0] value, input int count);
        @(negedge wr_clk);
        for (int i = 0; i < count; i++) begin
            repeat (xorshift32() & 1) @(negedge wr_clk);
            while (full) @(negedge wr_clk);
            push    = 1'b1;
            wr_data = value + FIFO_WIDTH'(i);
            @(negedge wr_clk);
            push = 1'b0;
        end
    endtask

    task automatic mixed_pop(input int count);
        @(negedge rd_clk);
        for (int i = 0; i < count; i++) begin
            repeat (xorshift32() & 1) @(negedge rd_clk);
            while (empty) @(negedge rd_clk);
            pop = 1'b1;
            @(negedge rd_clk);
            pop = 1'b0;
        end
    endtask

    initial begin
        bit ok;
        arst_n  = 1'b0;
        push    = 1'b0;
        pop     = 1'b0;
        wr_data = '0;
        read_patterns(ok);
        if (ok) begin
            apply_reset(10);
            for (int i = 0; i < op_q.size(); i++) begin
                u_fifo_checker.start_test();
                case (op_q[i])
                    OP_PUSH_BURST: push_burst(value_q[i], count_q[i]);
                    OP_POP_BURST:  pop_burst(count_q[i]);
                    OP_SETTLE:     repeat (count_q[i]) @(negedge rd_clk);
                    OP_RESET:      apply_reset(count_q[i]);
                    OP_MIXED: begin
                        fork
                            mixed_push(value_q[i], count_q[i]);
                            mixed_pop(count_q[i]);
                        join
                    end
                    default: begin
                        $display("pattern line %0d has an unknown opcode %s", i + 1, name_q[i]);
                        bad_lines++;
                    end
                endcase
                u_fifo_checker.end_test(name_q[i], count_q[i]);
            end
            u_fifo_checker.report();
        end
        if (ok && bad_lines == 0 && u_fifo_checker.fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
